//--- source/rv_pkg.sv
/*
  shared types of the rv32i pipeline
  opcode enumeration, instruction word views and the stage registers
  data port request and retire record
*/
`default_nettype none

package rv_pkg;

  typedef enum logic [6:0] {
    OP_COMPUTE = 7'b0110011,
    OP_IMM     = 7'b0010011,
    OP_LOAD    = 7'b0000011,
    OP_STORE   = 7'b0100011,
    OP_LUI     = 7'b0110111,
    OP_AUIPC   = 7'b0010111,
    OP_BRANCH  = 7'b1100011,
    OP_JAL     = 7'b1101111
  } opcode_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, read through the format that applies
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    instr_u      instr;
  } if_id_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    instr_u      instr;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;      // sign extended
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        uses_rs1;
    logic        uses_rs2;
    logic        is_load;
    logic        is_store;
    logic        reg_write;
  } id_ex_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic        reg_write;
    logic        is_load;
    logic        is_store;
    logic [31:0] result;      // address for loads and stores
    logic [31:0] store_data;
    logic [31:0] pc;
  } ex_mem_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic        reg_write;
    logic [31:0] data;
    logic [31:0] pc;
  } mem_wb_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
  } dmem_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
  } retire_t;

endpackage

`default_nettype wire

//--- source/alu.sv
/*
  integer alu for register and immediate operations
*/
`timescale 1ns/1ps
`default_nettype none

module alu
(
  input  logic [31:0] op_a,
  input  logic [31:0] op_b,
  input  logic [2:0]  funct3,
  input  logic        alt,     // sub and sra
  output logic [31:0] result
);

  logic [4:0] shamt;

  assign shamt = op_b[4:0];

  always_comb
  begin
    case (funct3)
      3'b000:
        result = alt ? op_a - op_b : op_a + op_b;
      3'b001:
        result = op_a << shamt;
      3'b010:
        result = {31'b0, $signed(op_a) < $signed(op_b)};
      3'b011:
        result = {31'b0, op_a < op_b};
      3'b100:
        result = op_a ^ op_b;
      3'b101:
      begin
        if (alt)
          result = $signed(op_a) >>> shamt;  // sign fill
        else
          result = op_a >> shamt;
      end
      3'b110:
        result = op_a | op_b;
      default:
        result = op_a & op_b;
    endcase
  end

endmodule

`default_nettype wire

//--- source/reg_file.sv
/*
  integer register file, x1 to x31
  two read ports with write-through from write-back
*/
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  mem_wb_t     wb
);

  logic [31:0] regs [1:31];
  logic        wr_en;

  assign wr_en = wb.valid && wb.reg_write && (wb.rd != 5'd0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int k = 1; k < 32; k++)
        regs[k] <= '0;
    end
    else if (wr_en)
      regs[wb.rd] <= wb.data;
  end

  function automatic logic [31:0] read_port(input logic [4:0] addr);
    if (addr == 5'd0)
      return '0;          // x0
    else if (wr_en && (addr == wb.rd))
      return wb.data;     // same cycle write wins
    else
      return regs[addr];
  endfunction

  always_comb
  begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
/*
  load-use hazard detection
*/
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import rv_pkg::*;
(
  input  logic [4:0] rs1_addr,
  input  logic [4:0] rs2_addr,
  input  logic       uses_rs1,
  input  logic       uses_rs2,
  input  id_ex_t     id_ex,
  output logic       stall
);

  logic load_in_ex;
  logic hit_rs1;
  logic hit_rs2;

  // load data only exists after the memory stage, so the consumer waits one cycle
  assign load_in_ex = id_ex.valid && id_ex.is_load && (id_ex.rd != 5'd0);
  assign hit_rs1    = uses_rs1 && (rs1_addr == id_ex.rd);
  assign hit_rs2    = uses_rs2 && (rs2_addr == id_ex.rd);
  assign stall      = load_in_ex && (hit_rs1 || hit_rs2);

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
/*
  instruction fetch
  pc register, redirect, stop on a zero word and the fetch/decode register
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import rv_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0
)
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        stall,
  input  redirect_t   redirect,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_word,
  output if_id_t      if_id,
  output logic        stopped
);

  logic [31:0] pc;

  assign imem_addr = pc;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc      <= RESET_PC;
      stopped <= 1'b0;
      if_id   <= '0;
    end
    else if (redirect.valid)
    begin
      pc          <= redirect.target;
      stopped     <= 1'b0;     // wrong path zero word is forgotten
      if_id.valid <= 1'b0;
    end
    else if (!stall)
    begin
      if (stopped || (imem_word == 32'b0))
      begin
        stopped     <= 1'b1;   // pc stays frozen
        if_id.valid <= 1'b0;
      end
      else
      begin
        pc    <= pc + 32'd4;
        if_id <= '{valid: 1'b1, pc: pc, instr: imem_word};
      end
    end
  end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
/*
  instruction decode
  field split, immediate build, control fields and the decode/execute register
*/
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  if_id_t      if_id,
  input  logic        stall,
  input  logic        flush,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  output logic [4:0]  rs1_addr,
  output logic [4:0]  rs2_addr,
  output logic        uses_rs1,
  output logic        uses_rs2,
  output id_ex_t      id_ex
);

  opcode_e     op;
  instr_u      w;
  logic [31:0] imm;
  logic        is_load;
  logic        is_store;
  logic        reg_write;

  assign w        = if_id.instr;
  assign op       = opcode_e'(w.r.opcode);
  assign rs1_addr = w.r.rs1;
  assign rs2_addr = w.r.rs2;

  always_comb
  begin
    imm       = '0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    reg_write = 1'b0;
    case (op)
      OP_COMPUTE:
      begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        reg_write = 1'b1;
      end
      OP_IMM, OP_LOAD:
      begin
        imm       = {{20{w.i.imm[11]}}, w.i.imm};
        uses_rs1  = 1'b1;
        is_load   = (op == OP_LOAD);
        reg_write = 1'b1;
      end
      OP_STORE:
      begin
        imm      = {{20{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        is_store = 1'b1;
      end
      OP_BRANCH:
      begin
        imm      = {{19{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      OP_LUI, OP_AUIPC:
      begin
        imm       = {w.u.imm, 12'b0};
        reg_write = 1'b1;
      end
      OP_JAL:
      begin
        imm       = {{11{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
        reg_write = 1'b1;           // link value
      end
      default:
        imm = '0;
    endcase
    if (!if_id.valid)
    begin
      uses_rs1 = 1'b0;   // an empty slot never stalls
      uses_rs2 = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      id_ex <= '0;
    else if (flush || stall)
      id_ex <= '0;   // bubble into execute
    else
      id_ex <= '{valid: if_id.valid, pc: if_id.pc, instr: w,
                 rs1_val: rs1_data, rs2_val: rs2_data, imm: imm,
                 rs1: w.r.rs1, rs2: w.r.rs2, rd: w.r.rd,
                 uses_rs1: uses_rs1, uses_rs2: uses_rs2,
                 is_load: is_load, is_store: is_store, reg_write: reg_write};
  end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
/*
  execute stage
  operand forwarding, alu, branch and jal resolution, execute/memory register
*/
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  id_ex_t    id_ex,
  output ex_mem_t   ex_mem,
  input  mem_wb_t   wb,
  output redirect_t redirect
);

  opcode_e     op;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_out;
  logic [2:0]  alu_fn;
  logic        alu_alt;
  logic        is_branch;
  logic        is_jal;
  logic        taken;

  // newest producer first, a load in memory has no data yet
  function automatic logic [31:0] forward(input logic [4:0] idx, input logic [31:0] reg_val,
                                          input ex_mem_t em, input mem_wb_t mw);
    if ((idx != 5'd0) && em.valid && em.reg_write && !em.is_load && (em.rd == idx))
      return em.result;
    else if ((idx != 5'd0) && mw.valid && mw.reg_write && (mw.rd == idx))
      return mw.data;
    else
      return reg_val;
  endfunction

  assign op        = opcode_e'(id_ex.instr.r.opcode);
  assign is_branch = (id_ex.instr.b.opcode == OP_BRANCH);
  assign is_jal    = (id_ex.instr.j.opcode == OP_JAL);
  assign rs1_val   = forward(id_ex.rs1, id_ex.rs1_val, ex_mem, wb);
  assign rs2_val   = forward(id_ex.rs2, id_ex.rs2_val, ex_mem, wb);

  always_comb
  begin
    alu_fn  = 3'b000;   // plain add for addresses, lui and auipc
    alu_alt = 1'b0;
    op_a    = rs1_val;
    op_b    = id_ex.imm;
    case (op)
      OP_COMPUTE:
      begin
        alu_fn  = id_ex.instr.r.funct3;
        alu_alt = id_ex.instr.r.funct7[5];
        op_b    = rs2_val;
      end
      OP_IMM:
      begin
        alu_fn  = id_ex.instr.r.funct3;
        alu_alt = (id_ex.instr.r.funct3 == 3'b101) && id_ex.instr.r.funct7[5];  // srai only
      end
      OP_LUI:
        op_a = 32'b0;
      OP_AUIPC:
        op_a = id_ex.pc;
      default:
        op_a = rs1_val;
    endcase
  end

  alu u_alu (
    .op_a   (op_a),
    .op_b   (op_b),
    .funct3 (alu_fn),
    .alt    (alu_alt),
    .result (alu_out)
  );

  always_comb
  begin
    case (id_ex.instr.b.funct3)
      3'b000:  taken = (rs1_val == rs2_val);
      3'b001:  taken = (rs1_val != rs2_val);
      3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
      3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      3'b110:  taken = (rs1_val < rs2_val);
      3'b111:  taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;
    endcase
  end

  // predicted not taken, so any taken branch or jal turns fetch around
  assign redirect = '{valid: id_ex.valid && ((is_branch && taken) || is_jal),
                      target: id_ex.pc + id_ex.imm};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ex_mem <= '0;
    else
      ex_mem <= '{valid: id_ex.valid, rd: id_ex.rd, reg_write: id_ex.reg_write,
                  is_load: id_ex.is_load, is_store: id_ex.is_store,
                  result: is_jal ? id_ex.pc + 32'd4 : alu_out,
                  store_data: rs2_val, pc: id_ex.pc};
  end

endmodule

`default_nettype wire

//--- source/mem_wb_stage.sv
/*
  memory stage
  data port request, load capture and the memory/write-back register
*/
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage import rv_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  ex_mem_t     ex_mem,
  output dmem_req_t   dmem_req,
  input  logic [31:0] dmem_rdata,
  output mem_wb_t     wb
);

  // word access only, memory answers in the same cycle
  assign dmem_req = '{addr: ex_mem.result,
                      wdata: ex_mem.store_data,
                      we: ex_mem.valid && ex_mem.is_store};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wb <= '0;
    else
    begin
      wb.valid     <= ex_mem.valid;
      wb.rd        <= ex_mem.rd;
      wb.reg_write <= ex_mem.reg_write;
      wb.data      <= ex_mem.is_load ? dmem_rdata : ex_mem.result;  // load data or alu value
      wb.pc        <= ex_mem.pc;
    end
  end

endmodule

`default_nettype wire

//--- source/rv_core.sv
/*
  five stage rv32i core
  fetch, decode, execute, memory and write-back with register file and hazard unit
*/
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0
)
(
  input  logic        clk,
  input  logic        rst_n,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_word,
  output dmem_req_t   dmem_req,
  input  logic [31:0] dmem_rdata,
  output retire_t     retire,
  output logic        halt
);

  if_id_t      if_id;
  id_ex_t      id_ex;
  ex_mem_t     ex_mem;
  mem_wb_t     wb;
  redirect_t   redirect;
  logic        stall;
  logic        stopped;
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic        uses_rs1;
  logic        uses_rs2;

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .redirect  (redirect),
    .imem_addr (imem_addr),
    .imem_word (imem_word),
    .if_id     (if_id),
    .stopped   (stopped)
  );

  decode_stage u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .if_id    (if_id),
    .stall    (stall),
    .flush    (redirect.valid),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .uses_rs1 (uses_rs1),
    .uses_rs2 (uses_rs2),
    .id_ex    (id_ex)
  );

  reg_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  hazard_unit u_hazard (
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .uses_rs1 (uses_rs1),
    .uses_rs2 (uses_rs2),
    .id_ex    (id_ex),
    .stall    (stall)
  );

  execute_stage u_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_ex    (id_ex),
    .ex_mem   (ex_mem),
    .wb       (wb),
    .redirect (redirect)
  );

  mem_wb_stage u_mem_wb (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_mem     (ex_mem),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .wb         (wb)
  );

  // only real register writes leave through the retire port
  assign retire = '{valid: wb.valid && wb.reg_write && (wb.rd != 5'd0),
                    pc: wb.pc, rd: wb.rd, data: wb.data};

  // drained once fetch has stopped and nothing is in flight
  assign halt = stopped && !if_id.valid && !id_ex.valid && !ex_mem.valid
                && !wb.valid && !redirect.valid;

endmodule

`default_nettype wire

//--- tb/rv_core_checker.sv
/*
  concurrent assertions on the core outputs
  bound into every rv_core instance
*/
`timescale 1ns/1ps
`default_nettype none

module rv_core_checker import rv_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      halt,
  input dmem_req_t dmem_req,
  input retire_t   retire
);

  // once drained the core stays halted until the next reset
  halt_held: assert property (@(posedge clk) disable iff (!rst_n) halt |=> halt)
    else $error("halt fell while reset was inactive");

  no_store_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halt |-> !dmem_req.we)
    else $error("data port write enable high while halted");

  no_x0_retire: assert property (@(posedge clk) disable iff (!rst_n)
    retire.valid |-> (retire.rd != 5'd0))
    else $error("retire carries destination x0");

endmodule

bind rv_core rv_core_checker u_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .halt     (halt),
  .dmem_req (dmem_req),
  .retire   (retire)
);

`default_nettype wire

//--- tb/tb_scoreboard.sv
/*
  scoreboard for the rv32i pipeline
  instruction level model of the program, expected write and store lists
  comparison of retires, stores and halt
*/
`timescale 1ns/1ps
`default_nettype none

module tb_scoreboard import rv_pkg::*;
#(
  parameter int          IMEM_WORDS = 256,
  parameter int          DMEM_WORDS = 64,
  parameter logic [31:0] START_PC   = 32'h0
)
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] prog [0:IMEM_WORDS-1],
  input  retire_t     retire,
  input  dmem_req_t   dmem_req,
  input  logic        halt,
  input  logic        drain_done,
  output logic        report_ready,
  output int          value_errors,
  output int          other_errors,
  output int          retire_count,
  output int          store_count
);

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
  } wr_rec_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } st_rec_t;

  wr_rec_t exp_wr[$];
  st_rec_t exp_st[$];
  int      n_value   = 0;
  int      n_other   = 0;
  int      n_retire  = 0;
  int      n_store   = 0;
  logic    model_ok  = 1'b1;
  logic    halt_seen = 1'b0;
  logic    done_q    = 1'b0;

  assign value_errors = n_value;
  assign other_errors = n_other;
  assign retire_count = n_retire;
  assign store_count  = n_store;
  assign report_ready = done_q;

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5:
      begin
        if (alt)
          r = $signed(a) >>> b[4:0];
        else
          r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // walks the program once from START_PC up to the zero word
  task automatic run_model();
    logic [31:0] x [0:31];
    logic [31:0] mem [0:DMEM_WORDS-1];
    logic [31:0] pc;
    logic [31:0] next;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] addr;
    logic        wr;
    logic        take;
    wr_rec_t     wrec;
    st_rec_t     srec;
    int          steps;
    for (int k = 0; k < 32; k++)
      x[k] = '0;
    for (int k = 0; k < DMEM_WORDS; k++)
      mem[k] = '0;
    pc    = START_PC;
    steps = 0;
    w     = prog[pc[9:2]];
    while ((w != 32'd0) && (steps < 4 * IMEM_WORDS))
    begin
      a    = x[w[19:15]];
      b    = x[w[24:20]];
      wr   = 1'b1;
      val  = '0;
      next = pc + 32'd4;
      case (w[6:0])
        OP_COMPUTE: val = alu_ref(w[14:12], w[30], a, b);
        OP_IMM:     val = alu_ref(w[14:12], (w[14:12] == 3'd5) && w[30], a,
                                  {{20{w[31]}}, w[31:20]});
        OP_LUI:     val = {w[31:12], 12'b0};
        OP_AUIPC:   val = pc + {w[31:12], 12'b0};
        OP_LOAD:
        begin
          addr = a + {{20{w[31]}}, w[31:20]};
          val  = mem[addr[7:2]];
        end
        OP_STORE:
        begin
          wr   = 1'b0;
          addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
          mem[addr[7:2]] = b;
          srec = '{addr: addr, data: b};
          exp_st.push_back(srec);
        end
        OP_BRANCH:
        begin
          wr = 1'b0;
          case (w[14:12])
            3'd0:    take = (a == b);
            3'd1:    take = (a != b);
            3'd4:    take = ($signed(a) < $signed(b));
            3'd5:    take = ($signed(a) >= $signed(b));
            3'd6:    take = (a < b);
            default: take = (a >= b);
          endcase
          if (take)
            next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
        OP_JAL:
        begin
          val  = pc + 32'd4;    // link
          next = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        default:
        begin
          wr       = 1'b0;
          model_ok = 1'b0;
        end
      endcase
      if (wr && (w[11:7] != 5'd0))
      begin
        x[w[11:7]] = val;
        wrec = '{pc: pc, rd: w[11:7], data: val};
        exp_wr.push_back(wrec);
      end
      pc = next;
      steps++;
      w = prog[pc[9:2]];
    end
    if (w != 32'd0)
      model_ok = 1'b0;
  endtask

  task automatic check_retire();
    wr_rec_t want;
    n_retire++;
    if (exp_wr.size() == 0)
    begin
      n_other++;
      $display("retire at pc %h to x%0d has no matching write in the model", retire.pc,
               retire.rd);
    end
    else
    begin
      want = exp_wr.pop_front();
      if (retire.pc !== want.pc)
      begin
        n_value++;
        $display("** Error retire.pc expected %h got %h", want.pc, retire.pc);
      end
      if (retire.rd !== want.rd)
      begin
        n_value++;
        $display("** Error retire.rd at pc %h expected %h got %h", want.pc, want.rd, retire.rd);
      end
      if (retire.data !== want.data)
      begin
        n_value++;
        $display("** Error retire.data at pc %h expected %h got %h", want.pc, want.data,
                 retire.data);
      end
    end
  endtask

  task automatic check_store();
    st_rec_t want;
    n_store++;
    if (exp_st.size() == 0)
    begin
      n_other++;
      $display("store to %h that the model never makes", dmem_req.addr);
    end
    else
    begin
      want = exp_st.pop_front();
      if (dmem_req.addr !== want.addr)
      begin
        n_value++;
        $display("** Error dmem_req.addr expected %h got %h", want.addr, dmem_req.addr);
      end
      if (dmem_req.wdata !== want.data)
      begin
        n_value++;
        $display("** Error dmem_req.wdata expected %h got %h", want.data, dmem_req.wdata);
      end
    end
  endtask

  task automatic final_check();
    if (!model_ok)
    begin
      n_other++;
      $display("model did not reach the zero word of the program");
    end
    if (exp_wr.size() != 0)
    begin
      n_other++;
      $display("%0d register writes of the model never retired", exp_wr.size());
    end
    if (exp_st.size() != 0)
    begin
      n_other++;
      $display("%0d stores of the model never reached the data port", exp_st.size());
    end
    if (!halt)
    begin
      n_other++;
      $display("halt is low at the end of the run");
    end
    done_q = 1'b1;
  endtask

  initial
  begin
    @(posedge rst_n);
    run_model();
  end

  // outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (retire.valid)
        check_retire();
      if (dmem_req.we)
        check_store();
      if (halt_seen && !halt)
      begin
        n_other++;
        $display("halt fell at %0t without a reset", $time);
      end
      if (halt && dmem_req.we)
      begin
        n_other++;
        $display("data store issued at %0t while halted", $time);
      end
      halt_seen = halt_seen || halt;
      if (drain_done && !done_q)
        final_check();
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_top.sv
/*
  testbench top for the rv32i pipeline
  clock module, random program builder, instruction and data memories
  reset, end of run report and watchdog
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock
#(
  parameter int HALF_NS = 4
)
(
  output logic clk
);

  initial clk = 1'b0;
  always #HALF_NS clk = ~clk;   // 8 ns period

endmodule

module tb_top import rv_pkg::*; ();

  localparam int          PROG_LEN       = 200;
  localparam int          IMEM_WORDS     = 256;
  localparam int          DMEM_WORDS     = 64;
  localparam int          RESET_CYCLES   = 5;
  localparam int          TIMEOUT_CYCLES = PROG_LEN * 6 + 50;
  localparam int unsigned SEED           = 32'h872a_e201;
  localparam logic [31:0] RESET_PC       = 32'h0;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];
  logic [31:0] imem_addr;
  logic [31:0] imem_word;
  logic [31:0] dmem_rdata;
  dmem_req_t   dmem_req;
  dmem_req_t   req_q;
  retire_t     retire;
  logic        halt;
  logic        drain_done;
  logic        report_ready;
  int          value_errors;
  int          other_errors;
  int          retire_count;
  int          store_count;

  tb_clock u_clock (.clk(clk));

  rv_core #(.RESET_PC(RESET_PC)) u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_addr  (imem_addr),
    .imem_word  (imem_word),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .retire     (retire),
    .halt       (halt)
  );

  tb_scoreboard #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS), .START_PC(RESET_PC))
    u_scoreboard (
    .clk          (clk),
    .rst_n        (rst_n),
    .prog         (imem),
    .retire       (retire),
    .dmem_req     (dmem_req),
    .halt         (halt),
    .drain_done   (drain_done),
    .report_ready (report_ready),
    .value_errors (value_errors),
    .other_errors (other_errors),
    .retire_count (retire_count),
    .store_count  (store_count)
  );

  // both memories answer in the same cycle
  assign imem_word  = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_req.addr[7:2]];

  // request sampled while stable and written 1 ns after the next rising edge
  always @(negedge clk)
  begin
    req_q = dmem_req;
    @(posedge clk);
    #1;
    if (rst_n && req_q.we)
      dmem[req_q.addr[7:2]] = req_q.wdata;
  end

  function automatic logic [4:0] pick_src(input logic [4:0] last_rd, input logic [4:0] prev_rd);
    int unsigned r;
    r = $urandom % 8;
    if (r < 3)
      return last_rd;
    else if (r < 5)
      return prev_rd;
    else
      return 5'(1 + $urandom % 7);
  endfunction

  task automatic build_program();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [4:0]  last_rd;
    logic [4:0]  prev_rd;
    logic [11:0] last_st;
    int unsigned kind;
    last_rd = 5'd1;
    prev_rd = 5'd2;
    last_st = 12'd0;
    for (int n = 0; n < PROG_LEN; n++)
    begin
      kind = $urandom % 16;
      rd   = ($urandom % 16 == 0) ? 5'd0 : 5'(1 + $urandom % 7);   // x0 now and then
      rs1  = pick_src(last_rd, prev_rd);
      rs2  = pick_src(last_rd, prev_rd);
      f3   = 3'($urandom % 8);
      imm  = {4'b0, 6'($urandom % DMEM_WORDS), 2'b00};   // word offset from x0
      boff = 13'(8 + 4 * ($urandom % 3));
      joff = 21'(8 + 4 * ($urandom % 3));
      if (kind < 4)
      begin
        f7 = (((f3 == 3'd0) || (f3 == 3'd5)) && ($urandom % 2 == 1)) ? 7'h20 : 7'h00;
        imem[n] = {f7, rs2, rs1, f3, rd, OP_COMPUTE};
      end
      else if (kind < 7)
      begin
        if (f3 == 3'd1)
          imm = {7'h00, 5'($urandom % 32)};
        else if (f3 == 3'd5)
          imm = {($urandom % 2 == 1) ? 7'h20 : 7'h00, 5'($urandom % 32)};
        else
          imm = 12'($urandom);
        imem[n] = {imm, rs1, f3, rd, OP_IMM};
      end
      else if (kind < 9)
        imem[n] = {20'($urandom), rd, (kind == 7) ? OP_LUI : OP_AUIPC};
      else if (kind < 11)
      begin
        if ($urandom % 2 == 1)
          imm = last_st;   // read back the latest store
        imem[n] = {imm, 5'd0, 3'b010, rd, OP_LOAD};
      end
      else if (kind < 13)
      begin
        last_st = imm;
        imem[n] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE};
      end
      else if (kind < 15)
      begin
        if (f3[2:1] == 2'b01)
          f3[2] = 1'b1;   // no branch with funct3 2 or 3
        imem[n] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OP_BRANCH};
      end
      else
        imem[n] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OP_JAL};
      if ((kind < 11) || (kind == 15))
      begin
        prev_rd = last_rd;
        last_rd = rd;
      end
    end
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst_n      = 1'b0;
    drain_done = 1'b0;
    for (int k = 0; k < IMEM_WORDS; k++)
      imem[k] = '0;   // zero words past the program stop fetch
    for (int k = 0; k < DMEM_WORDS; k++)
      dmem[k] = '0;
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
    while (!halt)
      @(negedge clk);
    repeat (8) @(posedge clk);   // halt has to hold
    #1 drain_done = 1'b1;
    wait (report_ready);
    $display("retires %0d stores %0d value errors %0d other errors %0d", retire_count,
             store_count, value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0))
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the core never drained", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- rv_pipe.f
source/rv_pkg.sv
source/alu.sv
source/reg_file.sv
source/hazard_unit.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/rv_core.sv
tb/rv_core_checker.sv
tb/tb_scoreboard.sv
tb/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the rv_pipe testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f rv_pipe.f \
  -o rv_pipe_sim > build.log 2>&1 \
  && ./obj_dir/rv_pipe_sim +verilator+error+limit+100 > "$log" 2>&1 \
  || echo "build or simulation ended with an error status"

# a missing log or a missing pass line counts as failure too
grep -q "TEST FAILED" "$log" && { echo "simulation failed, see $log"; exit 1; }
grep -q "TEST PASSED" "$log" || { echo "no pass line, see build.log and $log"; exit 1; }
echo "simulation passed"
exit 0
